// ==== include/cmd_seq_defs.svh ====
// command sequencer constants
// register map, pattern memory geometry and bus widths
`ifndef CMD_SEQ_DEFS_SVH
`define CMD_SEQ_DEFS_SVH

`define CMD_SEQ_ADDR_W          12
`define CMD_SEQ_DATA_W          32
`define CMD_SEQ_CNT_W           16      // bit counts and loop offsets

// pattern memory, 64 x 32 = 2048 bits
`define CMD_SEQ_MEM_WORDS       64
`define CMD_SEQ_MEM_AW          6

// register byte addresses
`define CMD_SEQ_ADDR_CMD        12'h000 // wr bit0 start, bit1 soft reset; rd bit0 ready
`define CMD_SEQ_ADDR_CONF       12'h004
`define CMD_SEQ_ADDR_SIZE       12'h008
`define CMD_SEQ_ADDR_REPEAT     12'h00C
`define CMD_SEQ_ADDR_START_REP  12'h010
`define CMD_SEQ_ADDR_STOP_REP   12'h014
`define CMD_SEQ_ADDR_MEM_BASE   12'h100 // pattern word k at base + 4k
`define CMD_SEQ_ADDR_MEM_END    12'h200 // first byte past the pattern words

`endif

// ==== source/cmd_seq_pkg.sv ====
// command sequencer types
// engine state encoding and the configuration word views
`include "cmd_seq_defs.svh"

package cmd_seq_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,   // first pattern word on its way out of memory
        st_send
    } seq_state_e;

    // field view of the CONF register, bit0 first
    typedef struct packed {
        logic [`CMD_SEQ_DATA_W-4:0] reserved;
        logic                       dis_cmd_pulse;  // bit2
        logic                       manchester;     // bit1
        logic                       en_ext_start;   // bit0
    } conf_fields_s;

    typedef union packed {
        logic [`CMD_SEQ_DATA_W-1:0] raw;    // as seen on the bus
        conf_fields_s               f;
    } conf_word_u;

endpackage

// ==== source/cmd_seq_regs.sv ====
// command sequencer register slave
// AXI4-Lite access to configuration, start/soft reset commands and pattern memory
`timescale 1ns/1ps
`include "cmd_seq_defs.svh"

module cmd_seq_regs (
    input  logic                        CMD_CLK_IN,
    input  logic                        RST_CMD_CLK,
    // write channels
    input  logic [`CMD_SEQ_ADDR_W-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`CMD_SEQ_DATA_W-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    // read channels
    input  logic [`CMD_SEQ_ADDR_W-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`CMD_SEQ_DATA_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // engine side
    input  logic                        ready,
    output cmd_seq_pkg::conf_word_u     conf,
    output logic [`CMD_SEQ_CNT_W-1:0]   cmd_size,
    output logic [`CMD_SEQ_DATA_W-1:0]  repeat_count,
    output logic [`CMD_SEQ_CNT_W-1:0]   start_repeat,
    output logic [`CMD_SEQ_CNT_W-1:0]   stop_repeat,
    output logic                        start,
    // pattern memory write port
    output logic                        mem_we,
    output logic [`CMD_SEQ_MEM_AW-1:0]  mem_waddr,
    output logic [`CMD_SEQ_DATA_W-1:0]  mem_wdata
);

    logic                       wr_accept;
    logic                       wr_hs;
    logic                       wr_is_cmd;
    logic                       wr_is_mem;
    logic                       soft_rst;
    logic                       rd_accept;
    logic                       rd_hs;
    logic [`CMD_SEQ_DATA_W-1:0] rd_mux;

    assign bresp = 2'b00;   // always OKAY
    assign rresp = 2'b00;

    assign wr_accept = awvalid && wvalid && !awready && !bvalid;
    assign wr_hs     = awready && awvalid && wready && wvalid;
    assign wr_is_cmd = (awaddr == `CMD_SEQ_ADDR_CMD);
    assign wr_is_mem = (awaddr >= `CMD_SEQ_ADDR_MEM_BASE) && (awaddr < `CMD_SEQ_ADDR_MEM_END);
    assign soft_rst  = wr_hs && wr_is_cmd && wdata[1];

    assign rd_accept = arvalid && !arready && !rvalid;
    assign rd_hs     = arready && arvalid;

    // write address/data accepted together, response held until taken
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            start   <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            if (wr_hs)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            start  <= wr_hs && wr_is_cmd && wdata[0];
            mem_we <= wr_hs && wr_is_mem;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (wr_hs) begin
            mem_waddr <= awaddr[`CMD_SEQ_MEM_AW+1:2];   // base is aligned to the array size
            mem_wdata <= wdata;
        end
    end

    // configuration, cleared by bus reset and soft reset alike
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            conf.raw     <= '0;
            cmd_size     <= '0;
            repeat_count <= {{(`CMD_SEQ_DATA_W-1){1'b0}}, 1'b1};
            start_repeat <= '0;
            stop_repeat  <= '0;
        end else if (wr_hs) begin
            case (awaddr)
                `CMD_SEQ_ADDR_CONF:      conf.raw     <= wdata;
                `CMD_SEQ_ADDR_SIZE:      cmd_size     <= wdata[`CMD_SEQ_CNT_W-1:0];
                `CMD_SEQ_ADDR_REPEAT:    repeat_count <= wdata;
                `CMD_SEQ_ADDR_START_REP: start_repeat <= wdata[`CMD_SEQ_CNT_W-1:0];
                `CMD_SEQ_ADDR_STOP_REP:  stop_repeat  <= wdata[`CMD_SEQ_CNT_W-1:0];
                default: ;
            endcase
        end
    end

    // readback, pattern memory and unmapped space read as zero
    always_comb begin
        case (araddr)
            `CMD_SEQ_ADDR_CMD:       rd_mux = {{(`CMD_SEQ_DATA_W-1){1'b0}}, ready};
            `CMD_SEQ_ADDR_CONF:      rd_mux = conf.raw;
            `CMD_SEQ_ADDR_SIZE:      rd_mux = {{(`CMD_SEQ_DATA_W-`CMD_SEQ_CNT_W){1'b0}}, cmd_size};
            `CMD_SEQ_ADDR_REPEAT:    rd_mux = repeat_count;
            `CMD_SEQ_ADDR_START_REP: rd_mux = {{(`CMD_SEQ_DATA_W-`CMD_SEQ_CNT_W){1'b0}},
                                               start_repeat};
            `CMD_SEQ_ADDR_STOP_REP:  rd_mux = {{(`CMD_SEQ_DATA_W-`CMD_SEQ_CNT_W){1'b0}},
                                               stop_repeat};
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= rd_accept;
            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (rd_hs)
            rdata <= rd_mux;
    end

    // held responses stay up and keep the channel closed to new requests
    a_bvalid_hold: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        bvalid && !bready |=> bvalid && !awready);
    a_rvalid_hold: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        rvalid && !rready |=> rvalid && !arready);

endmodule

// ==== source/cmd_seq_mem.sv ====
// command pattern memory
// bus write port, registered read port for the engine
`timescale 1ns/1ps
`include "cmd_seq_defs.svh"

module cmd_seq_mem (
    input  logic                        CMD_CLK_IN,
    input  logic                        we,
    input  logic [`CMD_SEQ_MEM_AW-1:0]  waddr,
    input  logic [`CMD_SEQ_DATA_W-1:0]  wdata,
    input  logic [`CMD_SEQ_MEM_AW-1:0]  raddr,
    output logic [`CMD_SEQ_DATA_W-1:0]  rdata
);

    // msb of word 0 is the first bit on the line
    logic [`CMD_SEQ_DATA_W-1:0] words [`CMD_SEQ_MEM_WORDS];

    always_ff @(posedge CMD_CLK_IN) begin
        if (we)
            words[waddr] <= wdata;
    end

    // one cycle read latency
    always_ff @(posedge CMD_CLK_IN) begin
        rdata <= words[raddr];
    end

endmodule

// ==== source/cmd_seq_engine.sv ====
// command sequence engine
// walks the pattern with inner-loop repeats, feeds the line encoder, reports ready
`timescale 1ns/1ps
`include "cmd_seq_defs.svh"

module cmd_seq_engine (
    input  logic                        CMD_CLK_IN,
    input  logic                        RST_CMD_CLK,
    input  logic                        start,
    input  logic                        ext_start,
    input  cmd_seq_pkg::conf_word_u     conf,
    input  logic [`CMD_SEQ_CNT_W-1:0]   cmd_size,
    input  logic [`CMD_SEQ_DATA_W-1:0]  repeat_count,
    input  logic [`CMD_SEQ_CNT_W-1:0]   start_repeat,
    input  logic [`CMD_SEQ_CNT_W-1:0]   stop_repeat,
    input  logic [`CMD_SEQ_DATA_W-1:0]  mem_rdata,
    input  logic                        advance,
    output logic [`CMD_SEQ_MEM_AW-1:0]  mem_raddr,
    output logic                        bit_valid,
    output logic                        bit_value,
    output logic                        cmd_start_flag,
    output logic                        ready
);

    cmd_seq_pkg::seq_state_e state;

    logic [`CMD_SEQ_CNT_W-1:0]  idx;        // bit on the encoder input
    logic [`CMD_SEQ_CNT_W-1:0]  next_idx;
    logic [`CMD_SEQ_CNT_W-1:0]  fetch_idx;
    logic [`CMD_SEQ_CNT_W-1:0]  loop_last;  // last bit of the repeated region
    logic [`CMD_SEQ_CNT_W-1:0]  size_last;
    logic [`CMD_SEQ_DATA_W-1:0] rep_total;
    logic [`CMD_SEQ_DATA_W-1:0] rep_left;   // loop-backs still to do
    logic                       launch;
    logic                       do_loop;
    logic                       last_bit;

    assign launch = start || (ext_start && conf.f.en_ext_start);

    assign loop_last = cmd_size - stop_repeat - 1'b1;
    assign size_last = cmd_size - 1'b1;
    assign rep_total = (repeat_count == '0) ? {{(`CMD_SEQ_DATA_W-1){1'b0}}, 1'b1}
                                            : repeat_count;

    assign do_loop  = (idx == loop_last) && (rep_left != '0);
    assign last_bit = (idx == size_last) && !do_loop;
    assign next_idx = do_loop ? start_repeat : idx + 1'b1;

    assign bit_valid = (state == cmd_seq_pkg::st_send);
    assign bit_value = mem_rdata[~idx[4:0]];   // msb first within a word

    // look one bit ahead on the advance cycle so the word is ready at the boundary
    always_comb begin
        fetch_idx = idx;
        if (bit_valid && advance)
            fetch_idx = next_idx;
    end

    assign mem_raddr = fetch_idx[`CMD_SEQ_MEM_AW+4:5];

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            state    <= cmd_seq_pkg::st_idle;
            idx      <= '0;
            rep_left <= '0;
        end else begin
            case (state)
                cmd_seq_pkg::st_idle: begin
                    if (launch) begin   // starts while busy are dropped here
                        state    <= cmd_seq_pkg::st_fetch;
                        idx      <= '0;
                        rep_left <= rep_total - 1'b1;
                    end
                end
                cmd_seq_pkg::st_fetch: begin
                    state <= cmd_seq_pkg::st_send;  // word 0 in mem_rdata next
                end
                cmd_seq_pkg::st_send: begin
                    if (advance) begin
                        if (last_bit) begin
                            state <= cmd_seq_pkg::st_idle;
                            idx   <= '0;
                        end else begin
                            idx <= next_idx;
                        end
                        if (do_loop)
                            rep_left <= rep_left - 1'b1;
                    end
                end
                default: state <= cmd_seq_pkg::st_idle;
            endcase
        end
    end

    // ready and start flag line up with the encoder's registered output
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            ready          <= 1'b1;
            cmd_start_flag <= 1'b0;
        end else begin
            ready          <= !bit_valid;
            cmd_start_flag <= bit_valid && ready && !conf.f.dis_cmd_pulse;    // first bit only
        end
    end

    a_state_legal: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        state inside {cmd_seq_pkg::st_idle, cmd_seq_pkg::st_fetch, cmd_seq_pkg::st_send});

    // ready only overlaps the first bit handed to the encoder
    a_no_bit_when_ready: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        bit_valid && ready |-> $past(state) == cmd_seq_pkg::st_fetch);

endmodule

// ==== source/cmd_line_encoder.sv ====
// command line encoder
// NRZ or IEEE 802.3 Manchester coding of the engine bit stream
`timescale 1ns/1ps

module cmd_line_encoder (
    input  logic CMD_CLK_IN,
    input  logic RST_CMD_CLK,
    input  logic manchester,
    input  logic bit_valid,
    input  logic bit_value,
    output logic advance,
    output logic cmd_data
);

    logic phase;        // second half of a manchester bit
    logic line_next;

    // last cycle of the bit period
    assign advance = bit_valid && (!manchester || phase);

    always_comb begin
        if (!bit_valid)
            line_next = 1'b0;           // idle line low
        else if (manchester && !phase)
            line_next = !bit_value;     // inverted first half
        else
            line_next = bit_value;
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            phase    <= 1'b0;
            cmd_data <= 1'b0;
        end else begin
            phase    <= bit_valid && manchester && !phase;
            cmd_data <= line_next;
        end
    end

endmodule

// ==== source/cmd_seq_top.sv ====
// command sequencer top
// register slave, pattern memory, sequencing engine and line encoder
`timescale 1ns/1ps
`include "cmd_seq_defs.svh"

module cmd_seq_top (
    input  logic                        CMD_CLK_IN,
    input  logic                        RST_CMD_CLK,
    input  logic [`CMD_SEQ_ADDR_W-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`CMD_SEQ_DATA_W-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`CMD_SEQ_ADDR_W-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`CMD_SEQ_DATA_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        ext_start,
    output logic                        cmd_data,
    output logic                        cmd_start_flag,
    output logic                        cmd_ready
);

    cmd_seq_pkg::conf_word_u    conf;
    logic [`CMD_SEQ_CNT_W-1:0]  cmd_size;
    logic [`CMD_SEQ_DATA_W-1:0] repeat_count;
    logic [`CMD_SEQ_CNT_W-1:0]  start_repeat;
    logic [`CMD_SEQ_CNT_W-1:0]  stop_repeat;
    logic                       start;
    logic                       mem_we;
    logic [`CMD_SEQ_MEM_AW-1:0] mem_waddr;
    logic [`CMD_SEQ_DATA_W-1:0] mem_wdata;
    logic [`CMD_SEQ_MEM_AW-1:0] mem_raddr;
    logic [`CMD_SEQ_DATA_W-1:0] mem_rdata;
    logic                       bit_valid;
    logic                       bit_value;
    logic                       advance;

    cmd_seq_regs u_regs (
        .CMD_CLK_IN(CMD_CLK_IN), .RST_CMD_CLK(RST_CMD_CLK),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .ready(cmd_ready), .conf(conf), .cmd_size(cmd_size),
        .repeat_count(repeat_count), .start_repeat(start_repeat),
        .stop_repeat(stop_repeat), .start(start),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata)
    );

    cmd_seq_mem u_mem (
        .CMD_CLK_IN(CMD_CLK_IN), .we(mem_we), .waddr(mem_waddr),
        .wdata(mem_wdata), .raddr(mem_raddr), .rdata(mem_rdata)
    );

    cmd_seq_engine u_engine (
        .CMD_CLK_IN(CMD_CLK_IN), .RST_CMD_CLK(RST_CMD_CLK),
        .start(start), .ext_start(ext_start), .conf(conf),
        .cmd_size(cmd_size), .repeat_count(repeat_count),
        .start_repeat(start_repeat), .stop_repeat(stop_repeat),
        .mem_rdata(mem_rdata), .advance(advance), .mem_raddr(mem_raddr),
        .bit_valid(bit_valid), .bit_value(bit_value),
        .cmd_start_flag(cmd_start_flag), .ready(cmd_ready)
    );

    cmd_line_encoder u_encoder (
        .CMD_CLK_IN(CMD_CLK_IN), .RST_CMD_CLK(RST_CMD_CLK),
        .manchester(conf.f.manchester), .bit_valid(bit_valid),
        .bit_value(bit_value), .advance(advance), .cmd_data(cmd_data)
    );

endmodule

// ==== dv/cmd_seq_tb.sv ====
// command sequencer testbench
// AXI4-Lite register and pattern setup, command line capture and reference compare
`timescale 1ns/1ps
`include "cmd_seq_defs.svh"

module cmd_seq_tb;

    localparam int STREAM_BITS   = 40 + 40 + 33 + 48 + 40;  // every run below
    localparam int MARGIN_CYCLES = 3000;
    localparam int BUS_LIMIT     = 50;

    logic                       CMD_CLK_IN;
    logic                       RST_CMD_CLK;
    logic [`CMD_SEQ_ADDR_W-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [`CMD_SEQ_DATA_W-1:0] wdata;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [`CMD_SEQ_ADDR_W-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    logic [`CMD_SEQ_DATA_W-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;
    logic                       ext_start;
    logic                       cmd_data;
    logic                       cmd_start_flag;
    logic                       cmd_ready;

    logic [31:0] pattern [4];   // bus-side copy of the pattern words
    bit          exp_line [$];  // expected line value per cycle
    bit          cap_line [$];
    bit          cap_flag [$];
    bit          exp_flag;
    int          runs_done;
    int          err_count;
    int          fail_count;
    int          seed = 35;
    event        run_end;

    cmd_seq_top dut (.*);

    initial begin
        CMD_CLK_IN = 1'b0;
        forever #10 CMD_CLK_IN = ~CMD_CLK_IN;
    end

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!(awready && wready) && n < BUS_LIMIT);
        if (!(awready && wready)) begin
            $display("write to 0x%03h was never accepted by the slave", addr);
            fail_count++;
        end
        @(negedge CMD_CLK_IN);  // handshake done on the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        assert (bvalid && bresp == 2'b00)
        else begin
            $display("ERR %0t: no OKAY write response for 0x%03h", $time, addr);
            err_count++;
        end
        @(negedge CMD_CLK_IN);
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!arready && n < BUS_LIMIT);
        if (!arready) begin
            $display("read of 0x%03h was never accepted by the slave", addr);
            fail_count++;
        end
        @(negedge CMD_CLK_IN);
        arvalid = 1'b0;
        data    = rdata;
        assert (rvalid && rresp == 2'b00)
        else begin
            $display("ERR %0t: no OKAY read data for 0x%03h", $time, addr);
            err_count++;
        end
        @(negedge CMD_CLK_IN);
    endtask

    task automatic check_reg(input logic [11:0] addr, input logic [31:0] expected);
        logic [31:0] value;
        axi_read(addr, value);
        assert (value == expected)
        else begin
            $display("ERR %0t: register 0x%03h read 0x%08h, expected 0x%08h",
                     $time, addr, value, expected);
            err_count++;
        end
    endtask

    // a response held by the master must block the next request on that channel
    task automatic check_backpressure();
        logic [31:0] value;
        bit          blocked;
        bready = 1'b0;
        rready = 1'b0;
        axi_write(`CMD_SEQ_ADDR_SIZE, 32'd7);
        axi_read(`CMD_SEQ_ADDR_SIZE, value);
        awaddr  = `CMD_SEQ_ADDR_SIZE;   // would overwrite if taken
        wdata   = 32'd9;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        araddr  = `CMD_SEQ_ADDR_CMD;
        arvalid = 1'b1;
        blocked = 1'b1;
        repeat (4) begin
            @(negedge CMD_CLK_IN);
            blocked = blocked && !awready && !arready && bvalid && rvalid;
        end
        assert (blocked && value == 32'd7 && rdata == value)
        else begin
            $display("ERR %0t: request accepted while a response was held", $time);
            err_count++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = 1'b1;
        rready  = 1'b1;
        @(negedge CMD_CLK_IN);
        check_reg(`CMD_SEQ_ADDR_SIZE, 32'd7);
    endtask

    // one pattern bit as it shows on the line, msb of each word first
    function automatic void append_line_bits(input int i, input bit manch);
        bit b;
        b = pattern[i / 32][31 - i % 32];
        if (manch)
            exp_line.push_back(!b); // inverted first half
        exp_line.push_back(b);
    endfunction

    // head, R-1 passes over the loop region, then the tail
    function automatic void build_expected(input int size, input int rep, input int start_rep,
                                           input int stop_rep, input bit manch);
        int e;
        int r;
        e = size - stop_rep;
        r = (rep < 1) ? 1 : rep;
        exp_line.delete();
        for (int i = 0; i < e; i++)
            append_line_bits(i, manch);
        for (int k = 1; k < r; k++) begin
            for (int i = start_rep; i < e; i++)
                append_line_bits(i, manch);
        end
        for (int i = e; i < size; i++)
            append_line_bits(i, manch);
    endfunction

    task automatic configure(input int size, input int rep, input int start_rep,
                             input int stop_rep, input logic [31:0] conf);
        axi_write(`CMD_SEQ_ADDR_CONF, conf);
        axi_write(`CMD_SEQ_ADDR_SIZE, size);
        axi_write(`CMD_SEQ_ADDR_REPEAT, rep);
        axi_write(`CMD_SEQ_ADDR_START_REP, start_rep);
        axi_write(`CMD_SEQ_ADDR_STOP_REP, stop_rep);
        build_expected(size, rep, start_rep, stop_rep, conf[1]);
        exp_flag = !conf[2];
    endtask

    task automatic pulse_ext_start();
        ext_start = 1'b1;
        @(negedge CMD_CLK_IN);
        ext_start = 1'b0;
    endtask

    task automatic wait_for_run(input int snap);
        int n;
        n = 0;
        while (runs_done == snap && n < 2 * exp_line.size() + 40) begin
            @(negedge CMD_CLK_IN);
            n++;
        end
        if (runs_done == snap) begin
            $display("command stream did not complete within %0d cycles", n);
            fail_count++;
        end
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (cmd_ready && n < 20) begin
            @(negedge CMD_CLK_IN);
            n++;
        end
        if (cmd_ready) begin
            $display("engine never dropped ready after a start");
            fail_count++;
        end
    endtask

    // one run is the stretch where cmd_ready is low
    initial begin : capture_line
        bit in_run;
        in_run = 1'b0;
        forever begin
            @(negedge CMD_CLK_IN);
            if (RST_CMD_CLK) begin
                in_run = 1'b0;
            end else if (!cmd_ready) begin
                in_run = 1'b1;
                cap_line.push_back(cmd_data);
                cap_flag.push_back(cmd_start_flag);
            end else begin
                assert (!cmd_data && !cmd_start_flag)
                else begin
                    $display("ERR %0t: command line active while ready", $time);
                    err_count++;
                end
                if (in_run) begin
                    in_run = 1'b0;
                    -> run_end;
                end
            end
        end
    end

    initial begin : compare_runs
        int flags;
        forever begin
            @(run_end);
            assert (cap_line.size() == exp_line.size())
            else begin
                $display("ERR %0t: stream of %0d cycles, expected %0d",
                         $time, cap_line.size(), exp_line.size());
                err_count++;
            end
            for (int i = 0; i < cap_line.size() && i < exp_line.size(); i++) begin
                assert (cap_line[i] == exp_line[i])
                else begin
                    $display("ERR %0t: line cycle %0d is %0b, expected %0b",
                             $time, i, cap_line[i], exp_line[i]);
                    err_count++;
                end
            end
            flags = 0;
            foreach (cap_flag[i]) begin
                if (cap_flag[i])
                    flags++;
            end
            assert (exp_flag ? (flags == 1 && cap_flag[0]) : (flags == 0))
            else begin
                $display("ERR %0t: %0d start flag cycles, expected %0d in the first cycle",
                         $time, flags, exp_flag);
                err_count++;
            end
            cap_line.delete();
            cap_flag.delete();
            runs_done++;
        end
    end

    initial begin : watchdog
        repeat (STREAM_BITS * 2 + MARGIN_CYCLES) @(posedge CMD_CLK_IN);
        $display("watchdog expired before the test sequence completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_sequence
        logic [31:0] v_conf;
        logic [31:0] v_size;
        logic [31:0] v_rep;
        logic [31:0] v_start;
        logic [31:0] v_stop;
        int          snap;
        RST_CMD_CLK = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;     // responses always taken
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        ext_start   = 1'b0;
        exp_flag    = 1'b1;
        runs_done   = 0;
        err_count   = 0;
        fail_count  = 0;
        repeat (8) @(negedge CMD_CLK_IN);
        RST_CMD_CLK = 1'b0;
        @(negedge CMD_CLK_IN);

        // reset values, memory and unmapped space read zero
        check_reg(`CMD_SEQ_ADDR_CMD, 32'h1);
        check_reg(`CMD_SEQ_ADDR_CONF, 32'h0);
        check_reg(`CMD_SEQ_ADDR_SIZE, 32'h0);
        check_reg(`CMD_SEQ_ADDR_REPEAT, 32'h1);
        check_reg(`CMD_SEQ_ADDR_START_REP, 32'h0);
        check_reg(`CMD_SEQ_ADDR_STOP_REP, 32'h0);
        check_reg(`CMD_SEQ_ADDR_MEM_BASE, 32'h0);
        check_reg(12'h020, 32'h0);

        v_conf  = $random(seed);
        v_size  = $random(seed);
        v_rep   = $random(seed);
        v_start = $random(seed);
        v_stop  = $random(seed);
        axi_write(`CMD_SEQ_ADDR_CONF, v_conf);
        axi_write(`CMD_SEQ_ADDR_SIZE, v_size);
        axi_write(`CMD_SEQ_ADDR_REPEAT, v_rep);
        axi_write(`CMD_SEQ_ADDR_START_REP, v_start);
        axi_write(`CMD_SEQ_ADDR_STOP_REP, v_stop);
        check_reg(`CMD_SEQ_ADDR_CONF, v_conf);
        check_reg(`CMD_SEQ_ADDR_SIZE, v_size & 32'h0000_ffff);  // 16-bit counts
        check_reg(`CMD_SEQ_ADDR_REPEAT, v_rep);
        check_reg(`CMD_SEQ_ADDR_START_REP, v_start & 32'h0000_ffff);
        check_reg(`CMD_SEQ_ADDR_STOP_REP, v_stop & 32'h0000_ffff);

        check_backpressure();

        for (int k = 0; k < 4; k++) begin
            pattern[k] = $random(seed);
            axi_write(`CMD_SEQ_ADDR_MEM_BASE + 12'(4 * k), pattern[k]);
        end

        // plain 40 bit NRZ run
        configure(40, 1, 0, 0, 32'h0);
        snap = runs_done;
        axi_write(`CMD_SEQ_ADDR_CMD, 32'h1);
        wait_for_run(snap);

        // inner loop, 14 + 2 x 10 + 6 cycles
        configure(20, 3, 4, 6, 32'h0);
        snap = runs_done;
        axi_write(`CMD_SEQ_ADDR_CMD, 32'h1);
        wait_for_run(snap);

        // manchester with start pulse off
        configure(33, 1, 0, 0, 32'h6);
        snap = runs_done;
        axi_write(`CMD_SEQ_ADDR_CMD, 32'h1);
        wait_for_run(snap);

        // external start, gated by en_ext_start
        configure(48, 1, 0, 0, 32'h0);
        snap = runs_done;
        pulse_ext_start();
        repeat (20) @(negedge CMD_CLK_IN);
        assert (runs_done == snap && cmd_ready)
        else begin
            $display("ERR %0t: ext_start launched a stream while disabled", $time);
            err_count++;
        end
        axi_write(`CMD_SEQ_ADDR_CONF, 32'h1);
        pulse_ext_start();
        wait_busy();
        axi_write(`CMD_SEQ_ADDR_CMD, 32'h1);    // both starts land mid-run
        pulse_ext_start();
        wait_for_run(snap);
        repeat (20) @(negedge CMD_CLK_IN);
        assert (runs_done == snap + 1 && cmd_ready)
        else begin
            $display("ERR %0t: start while busy produced another stream", $time);
            err_count++;
        end

        // soft reset clears registers, pattern stays
        axi_write(`CMD_SEQ_ADDR_REPEAT, 32'd5);
        axi_write(`CMD_SEQ_ADDR_START_REP, 32'd3);
        axi_write(`CMD_SEQ_ADDR_STOP_REP, 32'd7);
        axi_write(`CMD_SEQ_ADDR_CMD, 32'h2);
        check_reg(`CMD_SEQ_ADDR_CMD, 32'h1);
        check_reg(`CMD_SEQ_ADDR_CONF, 32'h0);
        check_reg(`CMD_SEQ_ADDR_SIZE, 32'h0);
        check_reg(`CMD_SEQ_ADDR_REPEAT, 32'h1);
        check_reg(`CMD_SEQ_ADDR_START_REP, 32'h0);
        check_reg(`CMD_SEQ_ADDR_STOP_REP, 32'h0);
        axi_write(`CMD_SEQ_ADDR_SIZE, 32'd40);
        build_expected(40, 1, 0, 0, 1'b0);
        exp_flag = 1'b1;
        snap = runs_done;
        axi_write(`CMD_SEQ_ADDR_CMD, 32'h1);
        wait_for_run(snap);

        $display("errors: %0d wrong values, %0d protocol or timeout", err_count, fail_count);
        if (err_count == 0 && fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/cmd_seq_pkg.sv
source/cmd_seq_regs.sv
source/cmd_seq_mem.sv
source/cmd_seq_engine.sv
source/cmd_line_encoder.sv
source/cmd_seq_top.sv
dv/cmd_seq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the command sequencer testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f vlog.f --top-module cmd_seq_tb -Mdir obj_dir -o cmd_seq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cmd_seq_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1
